// File: verilog/yadan_pkg.sv
`default_nettype none

package yadan_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111
    } opcode_e;

    // operation handed to execute
    typedef enum logic [7:0] {
        EXE_NONE = 8'h00,
        EXE_ADD,
        EXE_SUB,
        EXE_SLT,
        EXE_SLTU,
        EXE_XOR,
        EXE_OR,
        EXE_AND,
        EXE_SLL,
        EXE_SRL,
        EXE_SRA,
        EXE_LUI,
        EXE_JAL,
        EXE_JALR,
        EXE_BEQ,
        EXE_BNE,
        EXE_BLT,
        EXE_BGE,
        EXE_BLTU,
        EXE_BGEU,
        EXE_LB,
        EXE_LH,
        EXE_LW,
        EXE_LBU,
        EXE_LHU,
        EXE_SB,
        EXE_SH,
        EXE_SW
    } aluop_e;

    typedef enum logic [2:0] {
        RES_NONE    = 3'd0,
        RES_LOGIC   = 3'd1,
        RES_SHIFT   = 3'd2,
        RES_ARITH   = 3'd3,
        RES_COMPARE = 3'd4,
        RES_BRANCH  = 3'd5,
        RES_LOAD    = 3'd6,
        RES_STORE   = 3'd7
    } alusel_e;

    // write-back seen from a later stage
    typedef struct packed {
        logic                  wreg;
        logic [REG_ADDR_W-1:0] wd;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        aluop_e                aluop;
        alusel_e               alusel;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] reg_wd;
        logic                  reg1_read;
        logic                  reg2_read;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm_1;  // used when reg1_read is low
        logic [XLEN-1:0]       imm_2;  // used when reg2_read is low
    } decode_t;

    // to execute stage
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        aluop_e                aluop;
        alusel_e               alusel;
        logic [XLEN-1:0]       reg1;
        logic [XLEN-1:0]       reg2;
        logic [REG_ADDR_W-1:0] reg_wd;
        logic                  wreg;
    } id_out_t;

    function automatic logic is_load(aluop_e op);
        return op inside {EXE_LB, EXE_LH, EXE_LW, EXE_LBU, EXE_LHU};
    endfunction

endpackage

`default_nettype wire

// File: verilog/id_decoder.sv
`default_nettype none

module id_decoder (
    input  logic [yadan_pkg::XLEN-1:0] inst_i,
    input  logic [yadan_pkg::XLEN-1:0] pc_i,
    input  logic                       flush_i,
    output yadan_pkg::decode_t         dec_o
);

    yadan_pkg::opcode_e               opcode;
    logic [2:0]                       funct3;
    logic [yadan_pkg::REG_ADDR_W-1:0] rd;
    logic [yadan_pkg::XLEN-1:0]       imm_itype;
    logic [yadan_pkg::XLEN-1:0]       imm_utype;
    logic [yadan_pkg::XLEN-1:0]       shamt;
    logic                             bubble;
    yadan_pkg::decode_t               dec;

    assign opcode    = yadan_pkg::opcode_e'(inst_i[6:0]);
    assign funct3    = inst_i[14:12];
    assign rd        = inst_i[11:7];
    assign imm_itype = {{(yadan_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_utype = {inst_i[31:12], 12'b0};
    assign shamt     = {{(yadan_pkg::XLEN-5){1'b0}}, inst_i[24:20]};

    always_comb begin
        dec        = '0;
        dec.aluop  = yadan_pkg::EXE_NONE;
        dec.alusel = yadan_pkg::RES_NONE;
        dec.reg_wd = rd;
        dec.rs1    = inst_i[19:15];
        dec.rs2    = inst_i[24:20];
        bubble     = 1'b0;

        case (opcode)
            yadan_pkg::OP_LUI: begin
                dec.wreg   = 1'b1;
                dec.aluop  = yadan_pkg::EXE_LUI;
                dec.alusel = yadan_pkg::RES_SHIFT;
                dec.imm_2  = imm_utype;
            end
            yadan_pkg::OP_AUIPC: begin
                dec.wreg   = 1'b1;
                dec.aluop  = yadan_pkg::EXE_ADD;
                dec.alusel = yadan_pkg::RES_ARITH;
                dec.imm_1  = pc_i;  // pc + upper imm
                dec.imm_2  = imm_utype;
            end
            yadan_pkg::OP_JAL: begin
                dec.wreg   = 1'b1;
                dec.aluop  = yadan_pkg::EXE_JAL;
                dec.alusel = yadan_pkg::RES_BRANCH;
            end
            yadan_pkg::OP_JALR: begin
                dec.wreg      = 1'b1;
                dec.aluop     = yadan_pkg::EXE_JALR;
                dec.alusel    = yadan_pkg::RES_BRANCH;
                dec.reg1_read = 1'b1;
            end
            yadan_pkg::OP_BRANCH: begin
                dec.reg1_read = 1'b1;
                dec.reg2_read = 1'b1;
                case (funct3)
                    3'b000:  dec.aluop = yadan_pkg::EXE_BEQ;
                    3'b001:  dec.aluop = yadan_pkg::EXE_BNE;
                    3'b100:  dec.aluop = yadan_pkg::EXE_BLT;
                    3'b101:  dec.aluop = yadan_pkg::EXE_BGE;
                    3'b110:  dec.aluop = yadan_pkg::EXE_BLTU;
                    3'b111:  dec.aluop = yadan_pkg::EXE_BGEU;
                    default: bubble    = 1'b1;
                endcase
            end
            yadan_pkg::OP_LOAD: begin
                dec.wreg      = 1'b1;
                dec.alusel    = yadan_pkg::RES_LOAD;
                dec.reg1_read = 1'b1;
                case (funct3)
                    3'b000:  dec.aluop = yadan_pkg::EXE_LB;
                    3'b001:  dec.aluop = yadan_pkg::EXE_LH;
                    3'b010:  dec.aluop = yadan_pkg::EXE_LW;
                    3'b100:  dec.aluop = yadan_pkg::EXE_LBU;
                    3'b101:  dec.aluop = yadan_pkg::EXE_LHU;
                    default: bubble    = 1'b1;
                endcase
            end
            yadan_pkg::OP_STORE: begin
                dec.alusel    = yadan_pkg::RES_STORE;
                dec.reg1_read = 1'b1;
                dec.reg2_read = 1'b1;  // store data
                case (funct3)
                    3'b000:  dec.aluop = yadan_pkg::EXE_SB;
                    3'b001:  dec.aluop = yadan_pkg::EXE_SH;
                    3'b010:  dec.aluop = yadan_pkg::EXE_SW;
                    default: bubble    = 1'b1;
                endcase
            end
            yadan_pkg::OP_IMM: begin
                dec.wreg      = 1'b1;
                dec.reg1_read = 1'b1;
                dec.imm_2     = imm_itype;
                case (funct3)
                    3'b000: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH};
                    3'b010: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_SLT, yadan_pkg::RES_COMPARE};
                    3'b011: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_SLTU, yadan_pkg::RES_COMPARE};
                    3'b100: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_XOR, yadan_pkg::RES_LOGIC};
                    3'b110: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_OR, yadan_pkg::RES_LOGIC};
                    3'b111: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_AND, yadan_pkg::RES_LOGIC};
                    3'b001: begin
                        dec.aluop  = yadan_pkg::EXE_SLL;
                        dec.alusel = yadan_pkg::RES_SHIFT;
                        dec.imm_2  = shamt;
                    end
                    default: begin  // srli / srai
                        dec.aluop  = inst_i[30] ? yadan_pkg::EXE_SRA : yadan_pkg::EXE_SRL;
                        dec.alusel = yadan_pkg::RES_SHIFT;
                        dec.imm_2  = shamt;
                    end
                endcase
            end
            yadan_pkg::OP_REG: begin
                dec.wreg      = 1'b1;
                dec.reg1_read = 1'b1;
                dec.reg2_read = 1'b1;
                bubble        = inst_i[25];  // M extension not supported
                case (funct3)
                    3'b000: begin
                        dec.aluop  = inst_i[30] ? yadan_pkg::EXE_SUB : yadan_pkg::EXE_ADD;
                        dec.alusel = yadan_pkg::RES_ARITH;
                    end
                    3'b001: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_SLL, yadan_pkg::RES_SHIFT};
                    3'b010: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_SLT, yadan_pkg::RES_COMPARE};
                    3'b011: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_SLTU, yadan_pkg::RES_COMPARE};
                    3'b100: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_XOR, yadan_pkg::RES_LOGIC};
                    3'b110: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_OR, yadan_pkg::RES_LOGIC};
                    3'b111: {dec.aluop, dec.alusel} = {yadan_pkg::EXE_AND, yadan_pkg::RES_LOGIC};
                    default: begin
                        dec.aluop  = inst_i[30] ? yadan_pkg::EXE_SRA : yadan_pkg::EXE_SRL;
                        dec.alusel = yadan_pkg::RES_SHIFT;
                    end
                endcase
            end
            default: bubble = 1'b1;  // fence and unknown opcodes
        endcase
    end

    // a taken branch in execute kills whatever sits here
    always_comb begin
        dec_o = dec;
        if (bubble || (flush_i && (inst_i != '0))) begin
            dec_o        = '0;
            dec_o.aluop  = yadan_pkg::EXE_NONE;
            dec_o.alusel = yadan_pkg::RES_NONE;
        end
    end

endmodule

`default_nettype wire

// File: verilog/id_operand_sel.sv
`default_nettype none

module id_operand_sel (
    input  logic                             read_i,
    input  logic [yadan_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [yadan_pkg::XLEN-1:0]       imm_i,
    input  logic [yadan_pkg::XLEN-1:0]       rf_data_i,
    input  yadan_pkg::fwd_t                  ex_fwd_i,
    input  yadan_pkg::fwd_t                  mem_fwd_i,
    input  yadan_pkg::aluop_e                ex_aluop_i,
    output logic [yadan_pkg::XLEN-1:0]       operand_o,
    output logic                             load_hazard_o
);

    logic ex_hit;
    logic mem_hit;
    logic ex_is_load;

    assign ex_is_load = yadan_pkg::is_load(ex_aluop_i);
    assign ex_hit     = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit    = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        operand_o     = imm_i;  // port not read
        load_hazard_o = 1'b0;
        if (read_i) begin
            if (ex_is_load && (ex_fwd_i.wd == addr_i)) begin
                // load data not there yet, hold decode
                load_hazard_o = 1'b1;
                operand_o     = '0;
            end else if (addr_i == '0) begin
                operand_o = '0;
            end else if (ex_hit) begin
                operand_o = ex_fwd_i.wdata;  // youngest wins
            end else if (mem_hit) begin
                operand_o = mem_fwd_i.wdata;
            end else begin
                operand_o = rf_data_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/id_regfile.sv
`default_nettype none

module id_regfile (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             we_i,
    input  logic [yadan_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [yadan_pkg::XLEN-1:0]       wdata_i,
    input  logic [yadan_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [yadan_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [yadan_pkg::XLEN-1:0]       rdata1_o,
    output logic [yadan_pkg::XLEN-1:0]       rdata2_o
);

    logic [yadan_pkg::XLEN-1:0] regs [yadan_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < yadan_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;  // x0 stays zero
        end
    end

    // no bypass, a write shows up one cycle later
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`default_nettype none

module id_stage (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic [yadan_pkg::XLEN-1:0]       pc_i,
    input  logic [yadan_pkg::XLEN-1:0]       inst_i,
    input  yadan_pkg::fwd_t                  ex_fwd_i,
    input  yadan_pkg::aluop_e                ex_aluop_i,
    input  logic                             ex_branch_flag_i,
    input  yadan_pkg::fwd_t                  mem_fwd_i,
    input  logic                             wb_we_i,
    input  logic [yadan_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [yadan_pkg::XLEN-1:0]       wb_data_i,
    output yadan_pkg::id_out_t               id_o,
    output logic                             stall_o
);

    yadan_pkg::decode_t         dec;
    logic [yadan_pkg::XLEN-1:0] rf_rdata1;
    logic [yadan_pkg::XLEN-1:0] rf_rdata2;
    logic [yadan_pkg::XLEN-1:0] reg1;
    logic [yadan_pkg::XLEN-1:0] reg2;
    logic                       hazard1;
    logic                       hazard2;

    id_decoder i_decoder (
        .inst_i  (inst_i),
        .pc_i    (pc_i),
        .flush_i (ex_branch_flag_i),
        .dec_o   (dec)
    );

    id_regfile i_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (dec.rs1),
        .raddr2_i (dec.rs2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    id_operand_sel i_sel1 (
        .read_i        (dec.reg1_read),
        .addr_i        (dec.rs1),
        .imm_i         (dec.imm_1),
        .rf_data_i     (rf_rdata1),
        .ex_fwd_i      (ex_fwd_i),
        .mem_fwd_i     (mem_fwd_i),
        .ex_aluop_i    (ex_aluop_i),
        .operand_o     (reg1),
        .load_hazard_o (hazard1)
    );

    id_operand_sel i_sel2 (
        .read_i        (dec.reg2_read),
        .addr_i        (dec.rs2),
        .imm_i         (dec.imm_2),
        .rf_data_i     (rf_rdata2),
        .ex_fwd_i      (ex_fwd_i),
        .mem_fwd_i     (mem_fwd_i),
        .ex_aluop_i    (ex_aluop_i),
        .operand_o     (reg2),
        .load_hazard_o (hazard2)
    );

    assign stall_o = hazard1 | hazard2;

    always_comb begin
        id_o.pc     = pc_i;  // pc passes even on flush
        // zero inst is already zero, so the flag alone is enough here
        id_o.inst   = ex_branch_flag_i ? '0 : inst_i;
        id_o.aluop  = dec.aluop;
        id_o.alusel = dec.alusel;
        id_o.reg1   = reg1;
        id_o.reg2   = reg2;
        id_o.reg_wd = dec.reg_wd;
        id_o.wreg   = dec.wreg;
    end

endmodule

`default_nettype wire

// File: testbench/id_stage_properties.sv
`default_nettype none

module id_stage_properties (
    input logic                       clk,
    input logic                       arst_n_i,
    input logic [yadan_pkg::XLEN-1:0] inst_i,
    input yadan_pkg::aluop_e          ex_aluop_i,
    input logic                       ex_branch_flag_i,
    input yadan_pkg::id_out_t         id_i,
    input logic                       stall_i
);

    int unsigned assert_failures = 0;  // read by the testbench at the end

    // only a load in execute may hold decode
    stall_needs_load: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |-> yadan_pkg::is_load(ex_aluop_i))
    else begin
        $error("stall raised without a load in execute");
        assert_failures++;
    end

    flush_kills_inst: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ex_branch_flag_i && (inst_i != '0)) |-> (!id_i.wreg && (id_i.aluop == yadan_pkg::EXE_NONE)))
    else begin
        $error("flushed instruction still writes or carries an operation");
        assert_failures++;
    end

    no_write_in_reset: assert property (@(posedge clk) !arst_n_i |-> !id_i.wreg)
    else begin
        $error("write enable set while in reset");
        assert_failures++;
    end

endmodule

bind id_stage id_stage_properties i_props (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .inst_i           (inst_i),
    .ex_aluop_i       (ex_aluop_i),
    .ex_branch_flag_i (ex_branch_flag_i),
    .id_i             (id_o),
    .stall_i          (stall_o)
);

`default_nettype wire

// File: testbench/tb_id_stage.sv
`default_nettype none

module tb_id_stage;

    typedef struct packed {
        logic                             do_wr;
        logic [yadan_pkg::REG_ADDR_W-1:0] wr_addr;
        logic [yadan_pkg::XLEN-1:0]       wr_data;
        logic [yadan_pkg::XLEN-1:0]       pc;
        logic [yadan_pkg::XLEN-1:0]       inst;
        yadan_pkg::fwd_t                  ex_fwd;
        yadan_pkg::fwd_t                  mem_fwd;
        yadan_pkg::aluop_e                ex_aluop;
        logic                             branch;
        yadan_pkg::id_out_t               exp;
        logic                             exp_stall;
    } vec_t;

    logic                             clk;
    logic                             arst_n_i;
    logic [yadan_pkg::XLEN-1:0]       pc_i;
    logic [yadan_pkg::XLEN-1:0]       inst_i;
    yadan_pkg::fwd_t                  ex_fwd_i;
    yadan_pkg::aluop_e                ex_aluop_i;
    logic                             ex_branch_flag_i;
    yadan_pkg::fwd_t                  mem_fwd_i;
    logic                             wb_we_i;
    logic [yadan_pkg::REG_ADDR_W-1:0] wb_addr_i;
    logic [yadan_pkg::XLEN-1:0]       wb_data_i;
    yadan_pkg::id_out_t               id_o;
    logic                             stall_o;

    string       names[$];
    vec_t        vecs[$];
    vec_t        nv;       // side inputs of the next entry
    logic [31:0] pc_next;
    logic [31:0] lfsr_q = 32'hfd77cba3;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] r_fmt(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_fmt(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    task automatic add_case(input string name, input logic [31:0] inst,
                            input yadan_pkg::aluop_e op, input yadan_pkg::alusel_e sel,
                            input logic [31:0] r1, input logic [31:0] r2,
                            input logic [4:0] wd, input logic wr, input logic st);
        nv.pc          = pc_next;
        nv.inst        = inst;
        nv.exp.pc      = pc_next;
        nv.exp.inst    = (nv.branch && (inst != '0)) ? '0 : inst;  // flushed goes out as zero
        nv.exp.aluop   = op;
        nv.exp.alusel  = sel;
        nv.exp.reg1    = r1;
        nv.exp.reg2    = r2;
        nv.exp.reg_wd  = wd;
        nv.exp.wreg    = wr;
        nv.exp_stall   = st;
        names.push_back(name);
        vecs.push_back(nv);
        nv      = '0;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic build_table();
        logic [31:0] v5;
        logic [31:0] v6;
        logic [31:0] a;
        logic [31:0] b;
        rand_word(v5);
        rand_word(v6);
        rand_word(a);
        rand_word(b);
        nv      = '0;
        pc_next = 32'h0000_0100;
        add_case("reset_bubble", 32'h0, yadan_pkg::EXE_NONE, yadan_pkg::RES_NONE,
                 32'h0, 32'h0, 5'd0, 1'b0, 1'b0);
        {nv.do_wr, nv.wr_addr, nv.wr_data} = {1'b1, 5'd5, v5};
        add_case("fence", 32'h0000_000f, yadan_pkg::EXE_NONE, yadan_pkg::RES_NONE,
                 32'h0, 32'h0, 5'd0, 1'b0, 1'b0);
        {nv.do_wr, nv.wr_addr, nv.wr_data} = {1'b1, 5'd6, v6};
        add_case("add", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, v5, v6, 5'd7, 1'b1, 1'b0);
        add_case("sub", r_fmt(7'h20, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_SUB, yadan_pkg::RES_ARITH, v5, v6, 5'd7, 1'b1, 1'b0);
        add_case("xor", r_fmt(7'h00, 5'd6, 5'd5, 3'b100, 5'd12, 7'b0110011),
                 yadan_pkg::EXE_XOR, yadan_pkg::RES_LOGIC, v5, v6, 5'd12, 1'b1, 1'b0);
        add_case("slt", r_fmt(7'h00, 5'd6, 5'd5, 3'b010, 5'd13, 7'b0110011),
                 yadan_pkg::EXE_SLT, yadan_pkg::RES_COMPARE, v5, v6, 5'd13, 1'b1, 1'b0);
        add_case("sra", r_fmt(7'h20, 5'd6, 5'd5, 3'b101, 5'd14, 7'b0110011),
                 yadan_pkg::EXE_SRA, yadan_pkg::RES_SHIFT, v5, v6, 5'd14, 1'b1, 1'b0);
        add_case("addi_neg", i_fmt(12'hffb, 5'd5, 3'b000, 5'd8, 7'b0010011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, v5, 32'hffff_fffb, 5'd8, 1'b1, 1'b0);
        add_case("slli", i_fmt(12'h007, 5'd5, 3'b001, 5'd9, 7'b0010011),
                 yadan_pkg::EXE_SLL, yadan_pkg::RES_SHIFT, v5, 32'h7, 5'd9, 1'b1, 1'b0);
        add_case("lui", {20'habcde, 5'd10, 7'b0110111},
                 yadan_pkg::EXE_LUI, yadan_pkg::RES_SHIFT, 32'h0, 32'habcde000, 5'd10, 1'b1, 1'b0);
        add_case("auipc", {20'h12345, 5'd11, 7'b0010111},
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, pc_next, 32'h12345000, 5'd11, 1'b1, 1'b0);
        nv.ex_fwd = {1'b1, 5'd0, a};  // x0 write must not leak through
        add_case("fwd_x0", r_fmt(7'h00, 5'd6, 5'd0, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, 32'h0, v6, 5'd7, 1'b1, 1'b0);
        nv.ex_fwd  = {1'b1, 5'd5, a};
        nv.mem_fwd = {1'b1, 5'd5, b};
        add_case("fwd_ex_over_mem", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, a, v6, 5'd7, 1'b1, 1'b0);
        nv.mem_fwd = {1'b1, 5'd5, b};
        add_case("fwd_mem", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, b, v6, 5'd7, 1'b1, 1'b0);
        {nv.ex_aluop, nv.ex_fwd} = {yadan_pkg::EXE_LW, 1'b1, 5'd6, a};
        add_case("load_use", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, v5, 32'h0, 5'd7, 1'b1, 1'b1);
        {nv.ex_aluop, nv.ex_fwd} = {yadan_pkg::EXE_LW, 1'b1, 5'd6, a};
        add_case("load_addi", i_fmt(12'h006, 5'd5, 3'b000, 5'd8, 7'b0010011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, v5, 32'h6, 5'd8, 1'b1, 1'b0);
        {nv.ex_aluop, nv.ex_fwd} = {yadan_pkg::EXE_SW, 1'b0, 5'd6, a};
        add_case("store_in_ex", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_ADD, yadan_pkg::RES_ARITH, v5, v6, 5'd7, 1'b1, 1'b0);
        nv.branch = 1'b1;
        add_case("flush", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, 7'b0110011),
                 yadan_pkg::EXE_NONE, yadan_pkg::RES_NONE, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0);
        // offset 8 lands in bits 11:7
        add_case("sw", r_fmt(7'h00, 5'd6, 5'd5, 3'b010, 5'd8, 7'b0100011),
                 yadan_pkg::EXE_SW, yadan_pkg::RES_STORE, v5, v6, 5'd8, 1'b0, 1'b0);
        add_case("beq", r_fmt(7'h00, 5'd6, 5'd5, 3'b000, 5'd8, 7'b1100011),
                 yadan_pkg::EXE_BEQ, yadan_pkg::RES_NONE, v5, v6, 5'd8, 1'b0, 1'b0);
        add_case("bgeu", r_fmt(7'h00, 5'd6, 5'd5, 3'b111, 5'd8, 7'b1100011),
                 yadan_pkg::EXE_BGEU, yadan_pkg::RES_NONE, v5, v6, 5'd8, 1'b0, 1'b0);
        add_case("jal", {20'h0, 5'd1, 7'b1101111},
                 yadan_pkg::EXE_JAL, yadan_pkg::RES_BRANCH, 32'h0, 32'h0, 5'd1, 1'b1, 1'b0);
        add_case("unknown", 32'hffff_ffff, yadan_pkg::EXE_NONE, yadan_pkg::RES_NONE,
                 32'h0, 32'h0, 5'd0, 1'b0, 1'b0);
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test, field, exp, act);
            value_errors++;
        end
    endtask

    task automatic apply_case(input int k);
        vec_t  v;
        string nm;
        v  = vecs[k];
        nm = names[k];
        @(negedge clk);
        if (v.do_wr) begin
            {wb_we_i, wb_addr_i, wb_data_i} = {1'b1, v.wr_addr, v.wr_data};
            @(posedge clk);
            @(negedge clk);
            wb_we_i = 1'b0;
        end
        pc_i             = v.pc;
        inst_i           = v.inst;
        ex_fwd_i         = v.ex_fwd;
        mem_fwd_i        = v.mem_fwd;
        ex_aluop_i       = v.ex_aluop;
        ex_branch_flag_i = v.branch;
        @(posedge clk);
        check_value(nm, "pc", v.exp.pc, id_o.pc);
        check_value(nm, "inst", v.exp.inst, id_o.inst);
        check_value(nm, "aluop", 32'(v.exp.aluop), 32'(id_o.aluop));
        check_value(nm, "alusel", 32'(v.exp.alusel), 32'(id_o.alusel));
        check_value(nm, "reg1", v.exp.reg1, id_o.reg1);
        check_value(nm, "reg2", v.exp.reg2, id_o.reg2);
        check_value(nm, "reg_wd", 32'(v.exp.reg_wd), 32'(id_o.reg_wd));
        check_value(nm, "wreg", 32'(v.exp.wreg), 32'(id_o.wreg));
        check_value(nm, "stall", 32'(v.exp_stall), 32'(stall_o));
    endtask

    initial begin
        int cnt;
        int total;
        arst_n_i         = 1'b0;
        pc_i             = '0;
        inst_i           = '0;
        ex_fwd_i         = '0;
        ex_aluop_i       = yadan_pkg::EXE_NONE;
        ex_branch_flag_i = 1'b0;
        mem_fwd_i        = '0;
        wb_we_i          = 1'b0;
        wb_addr_i        = '0;
        wb_data_i        = '0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        cnt = 0;
        while ((stall_o !== 1'b0) && (cnt < 20)) begin
            @(posedge clk);
            cnt++;
        end
        if (stall_o !== 1'b0) begin
            $display("stall did not clear within 20 cycles after reset");
            other_errors++;
        end

        for (int k = 0; k < vecs.size(); k++) begin
            apply_case(k);
        end

        @(negedge clk);
        total = value_errors + other_errors + int'(i_dut.i_props.assert_failures);
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, i_dut.i_props.assert_failures);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/yadan_pkg.sv
verilog/id_decoder.sv
verilog/id_operand_sel.sv
verilog/id_regfile.sv
verilog/id_stage.sv
testbench/id_stage_properties.sv
testbench/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_id_stage \
    -f verilog.f -Mdir "$BUILD_DIR" -o Vtb_id_stage > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_id_stage" +verilator+error+limit+100 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    echo "testbench reported failure"
    exit 1
fi
if ! grep -q "sim passed" "$SIM_LOG"; then
    echo "no pass line found in $SIM_LOG"
    exit 1
fi

echo "run ok"
exit 0
